//--- common/frame_pkg.sv
// ==============================
// frame_pkg
// shared types and CRC constants of the test-frame generator
// ==============================

`default_nettype none

package frame_pkg;

    localparam int WORD_W = 16;  // payload, seed, polynomial and CRC width
    localparam int LEN_W  = 8;   // frame length width, up to 255 payload words

    // one data word on the link
    typedef logic [WORD_W-1:0] word_t;

    // payload length of a frame in words
    typedef logic [LEN_W-1:0] len_t;

    // phases of a frame
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,  // waiting for an accepted start
        ST_PAYLOAD = 2'd1,  // one LFSR word per cycle
        ST_CRC     = 2'd2   // single cycle that appends the CRC word
    } frame_state_t;

    // CRC-16-CCITT, x^16 + x^12 + x^5 + 1 in normal form
    localparam word_t CRC_INIT = 16'hffff;
    localparam word_t CRC_POLY = 16'h1021;

endpackage

`default_nettype wire

//--- hw/lfsr_gen.sv
// ==============================
// lfsr_gen
// shift-left LFSR that builds the payload words
// ==============================

`timescale 1ns/100ps
`default_nettype none

module lfsr_gen (
    input  wire logic             clk_i,
    input  wire logic             rstn_i,
    input  wire logic             load_i,
    input  wire frame_pkg::word_t seed_i,
    input  wire frame_pkg::word_t poly_i,
    input  wire logic             step_i,
    output frame_pkg::word_t      state_o
);

    frame_pkg::word_t state_q;
    frame_pkg::word_t poly_q;
    logic             feedback;

    assign feedback = ^(state_q & poly_q);  // parity of the tapped bits

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= '0;
        end else if (load_i) begin
            state_q <= seed_i;  // first payload word is the seed itself
        end else if (step_i) begin
            state_q <= {state_q[frame_pkg::WORD_W-2:0], feedback};
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            poly_q <= poly_i;  // taps stay fixed for the whole frame
        end
    end

    assign state_o = state_q;

    // an all-zero seed would lock the register at zero for the whole frame
    seed_nonzero_a : assert property (@(posedge clk_i) disable iff (!rstn_i)
        load_i |-> (seed_i != '0))
        else $error("lfsr_gen: seed_i must be nonzero at load");

endmodule

`default_nettype wire

//--- hw/word_counter.sv
// ==============================
// word_counter
// counts down the payload words left in a frame
// ==============================

`timescale 1ns/100ps
`default_nettype none

module word_counter (
    input  wire logic            clk_i,
    input  wire logic            rstn_i,
    input  wire logic            load_i,
    input  wire frame_pkg::len_t len_i,
    input  wire logic            step_i,
    output logic                 last_word_o
);

    frame_pkg::len_t count_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= len_i - 8'd1;  // zero length is filtered out by the FSM
        end else if (step_i && (count_q != '0)) begin
            count_q <= count_q - 8'd1;
        end
    end

    assign last_word_o = (count_q == '0);  // current payload word is the final one

    // the step taken at count zero closes the payload, so no step may follow it
    no_step_past_end_a : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (step_i && (count_q == '0) && !load_i) |=> !step_i || load_i)
        else $error("word_counter: step after the final payload word");

endmodule

`default_nettype wire

//--- hw/frame_fsm.sv
// ==============================
// frame_fsm
// sequences idle, payload and CRC phases of one frame
// ==============================

`timescale 1ns/100ps
`default_nettype none

module frame_fsm (
    input  wire logic            clk_i,
    input  wire logic            rstn_i,
    input  wire logic            start_i,
    input  wire frame_pkg::len_t len_i,
    input  wire logic            last_word_i,
    output logic                 load_o,
    output logic                 payload_stb_o,
    output logic                 crc_stb_o,
    output logic                 busy_o
);

    frame_pkg::frame_state_t state_q;
    frame_pkg::frame_state_t state_d;
    logic                    accept;

    // starts in a running frame and empty frames are dropped here
    assign accept = start_i && (state_q == frame_pkg::ST_IDLE) && (len_i != '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            frame_pkg::ST_IDLE: begin
                if (accept) begin
                    state_d = frame_pkg::ST_PAYLOAD;
                end
            end
            frame_pkg::ST_PAYLOAD: begin
                if (last_word_i) begin
                    state_d = frame_pkg::ST_CRC;  // final payload strobe in this cycle
                end
            end
            frame_pkg::ST_CRC: begin
                state_d = frame_pkg::ST_IDLE;  // one CRC strobe only
            end
            default: begin
                state_d = frame_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= frame_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign load_o        = accept;  // seed, length and CRC init taken at the start edge
    assign payload_stb_o = (state_q == frame_pkg::ST_PAYLOAD);
    assign crc_stb_o     = (state_q == frame_pkg::ST_CRC);
    assign busy_o        = (state_q != frame_pkg::ST_IDLE);

endmodule

`default_nettype wire

//--- hw/crc_append.sv
// ==============================
// crc_append
// running CRC-16 over the payload and the output word register
// ==============================

`timescale 1ns/100ps
`default_nettype none

module crc_append (
    input  wire logic             clk_i,
    input  wire logic             rstn_i,
    input  wire logic             load_i,
    input  wire logic             payload_stb_i,
    input  wire frame_pkg::word_t payload_i,
    input  wire logic             crc_stb_i,
    output logic                  word_valid_o,
    output frame_pkg::word_t      word_o,
    output logic                  last_o
);

    frame_pkg::word_t crc_q;

    // one CRC step per data bit, MSB first
    function automatic frame_pkg::word_t crc_bit(
        input frame_pkg::word_t crc,
        input logic             data
    );
        logic fb;
        fb = crc[frame_pkg::WORD_W-1] ^ data;
        crc_bit = {crc[frame_pkg::WORD_W-2:0], 1'b0};
        if (fb) begin
            crc_bit = crc_bit ^ frame_pkg::CRC_POLY;
        end
    endfunction

    // folds a whole payload word into the CRC
    function automatic frame_pkg::word_t crc_word(
        input frame_pkg::word_t crc,
        input frame_pkg::word_t data
    );
        crc_word = crc;
        for (int i = frame_pkg::WORD_W - 1; i >= 0; i--) begin
            crc_word = crc_bit(crc_word, data[i]);
        end
    endfunction

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            crc_q <= frame_pkg::CRC_INIT;
        end else if (payload_stb_i) begin
            crc_q <= crc_word(crc_q, payload_i);
        end
    end

    // payload and CRC words leave through the same register
    always_ff @(posedge clk_i) begin
        if (crc_stb_i) begin
            word_o <= crc_q;  // already covers the final payload word
        end else if (payload_stb_i) begin
            word_o <= payload_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            word_valid_o <= 1'b0;
            last_o       <= 1'b0;
        end else begin
            word_valid_o <= payload_stb_i || crc_stb_i;
            last_o       <= crc_stb_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/frame_gen_top.sv
// ==============================
// frame_gen_top
// test-frame generator, LFSR payload followed by a CRC-16 word
// ==============================

`timescale 1ns/100ps
`default_nettype none

module frame_gen_top (
    input  wire logic             clk_i,
    input  wire logic             rstn_i,
    input  wire logic             start_i,
    input  wire frame_pkg::len_t  len_i,
    input  wire frame_pkg::word_t seed_i,
    input  wire frame_pkg::word_t poly_i,
    output logic                  word_valid_o,
    output frame_pkg::word_t      word_o,
    output logic                  last_o,
    output logic                  busy_o
);

    logic             load;
    logic             payload_stb;
    logic             crc_stb;
    logic             last_word;
    frame_pkg::word_t lfsr_word;

    frame_fsm u_frame_fsm (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .start_i       (start_i),
        .len_i         (len_i),
        .last_word_i   (last_word),
        .load_o        (load),
        .payload_stb_o (payload_stb),
        .crc_stb_o     (crc_stb),
        .busy_o        (busy_o)
    );

    word_counter u_word_counter (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .load_i      (load),
        .len_i       (len_i),
        .step_i      (payload_stb),
        .last_word_o (last_word)
    );

    lfsr_gen u_lfsr_gen (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .load_i  (load),
        .seed_i  (seed_i),
        .poly_i  (poly_i),
        .step_i  (payload_stb),
        .state_o (lfsr_word)
    );

    crc_append u_crc_append (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .load_i        (load),
        .payload_stb_i (payload_stb),
        .payload_i     (lfsr_word),
        .crc_stb_i     (crc_stb),
        .word_valid_o  (word_valid_o),
        .word_o        (word_o),
        .last_o        (last_o)
    );

endmodule

`default_nettype wire

//--- testbench/frame_checker.sv
// ==============================
// frame_checker
// reference model of the frame generator, compares every DUT output cycle
// ==============================

`timescale 1ns/100ps
`default_nettype none

module frame_checker (
    input  wire logic             clk_i,
    input  wire logic             rstn_i,
    input  wire logic             start_i,
    input  wire frame_pkg::len_t  len_i,
    input  wire frame_pkg::word_t seed_i,
    input  wire frame_pkg::word_t poly_i,
    input  wire logic             word_valid_i,
    input  wire frame_pkg::word_t word_i,
    input  wire logic             last_i,
    input  wire logic             busy_i,
    output int                    error_count_o,
    output int                    word_count_o,
    output int                    frame_count_o
);

    frame_pkg::frame_state_t phase;  // model phase of the cycle that ends at the edge
    frame_pkg::word_t        lfsr_m;
    frame_pkg::word_t        poly_m;
    frame_pkg::word_t        crc_m;
    frame_pkg::word_t        exp_word;
    logic                    exp_valid;
    logic                    exp_last;
    logic                    exp_busy;
    int                      pay_left;

    function automatic frame_pkg::word_t next_lfsr(input frame_pkg::word_t s,
                                                   input frame_pkg::word_t taps);
        next_lfsr = {s[14:0], ^(s & taps)};  // shift left, parity of tapped bits into bit 0
    endfunction

    // CRC-16-CCITT over one word, MSB first
    function automatic frame_pkg::word_t crc_fold(input frame_pkg::word_t crc,
                                                  input frame_pkg::word_t data);
        frame_pkg::word_t c;
        logic             top;
        c = crc;
        for (int i = 15; i >= 0; i--) begin
            top = c[15];
            c = c << 1;
            if (top != data[i]) begin
                c = c ^ frame_pkg::CRC_POLY;
            end
        end
        crc_fold = c;
    endfunction

    task automatic compare_value(input string name, input frame_pkg::word_t got,
                                 input frame_pkg::word_t exp);
        if (got !== exp) begin
            error_count_o++;
            $display("error: %s got 0x%04h expected 0x%04h in phase %s at %0t",
                     name, got, exp, phase.name(), $time);
        end
    endtask

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            phase = frame_pkg::ST_IDLE;
            exp_valid = 1'b0;
            exp_last = 1'b0;
            exp_busy = 1'b0;
            pay_left = 0;
            error_count_o = 0;
            word_count_o = 0;
            frame_count_o = 0;
        end else begin
            compare_value("word_valid_o", {15'd0, word_valid_i}, {15'd0, exp_valid});
            compare_value("last_o", {15'd0, last_i}, {15'd0, exp_last});
            compare_value("busy_o", {15'd0, busy_i}, {15'd0, exp_busy});
            if (exp_valid) begin
                compare_value("word_o", word_i, exp_word);
            end
            if (word_valid_i === 1'b1) begin
                word_count_o++;
            end
            if ((word_valid_i === 1'b1) && (last_i === 1'b1)) begin
                frame_count_o++;
            end
            case (phase)
                frame_pkg::ST_IDLE: begin
                    exp_valid = 1'b0;
                    exp_last = 1'b0;
                    if (start_i && (len_i != '0)) begin  // only an idle, nonempty start counts
                        lfsr_m = seed_i;
                        poly_m = poly_i;
                        crc_m = frame_pkg::CRC_INIT;
                        pay_left = int'(len_i);
                        phase = frame_pkg::ST_PAYLOAD;
                    end
                end
                frame_pkg::ST_PAYLOAD: begin
                    exp_valid = 1'b1;
                    exp_last = 1'b0;
                    exp_word = lfsr_m;
                    crc_m = crc_fold(crc_m, lfsr_m);
                    lfsr_m = next_lfsr(lfsr_m, poly_m);
                    pay_left--;
                    if (pay_left == 0) begin
                        phase = frame_pkg::ST_CRC;
                    end
                end
                default: begin
                    exp_valid = 1'b1;  // CRC word follows the last payload word
                    exp_last = 1'b1;
                    exp_word = crc_m;
                    phase = frame_pkg::ST_IDLE;
                end
            endcase
            exp_busy = (phase != frame_pkg::ST_IDLE);
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_frame_gen.sv
// ==============================
// tb_frame_gen
// random frames into the generator, with checker and watchdog
// ==============================

`timescale 1ns/100ps
`default_nettype none

module tb_frame_gen;

    localparam int NUM_FRAMES = 40;
    localparam int MAX_LEN    = 24;
    // each frame needs at most MAX_LEN + 8 cycles of 4 ns, plus reset and drain
    localparam int TIMEOUT_NS = NUM_FRAMES * (MAX_LEN + 8) * 4 + 200;

    logic             clk;
    logic             rstn;
    logic             start;
    frame_pkg::len_t  len;
    frame_pkg::word_t seed;
    frame_pkg::word_t poly;
    logic             word_valid;
    frame_pkg::word_t word;
    logic             last;
    logic             busy;
    int               error_count;
    int               word_count;
    int               frame_count;
    int               expected_words;
    int               total_errors;
    logic [31:0]      rng_state;

    frame_gen_top UUT (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .start_i      (start),
        .len_i        (len),
        .seed_i       (seed),
        .poly_i       (poly),
        .word_valid_o (word_valid),
        .word_o       (word),
        .last_o       (last),
        .busy_o       (busy)
    );

    frame_checker u_checker (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .start_i       (start),
        .len_i         (len),
        .seed_i        (seed),
        .poly_i        (poly),
        .word_valid_i  (word_valid),
        .word_i        (word),
        .last_i        (last),
        .busy_i        (busy),
        .error_count_o (error_count),
        .word_count_o  (word_count),
        .frame_count_o (frame_count)
    );

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        galois_step = {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);  // x^32+x^22+x^2+x+1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], rng_state[0]};
            rng_state = galois_step(rng_state);
        end
    endtask

    // one accepted frame, then wait until busy drops, maybe with a stray start inside
    task automatic run_frame;
        logic [31:0]     r;
        frame_pkg::len_t flen;
        logic            do_extra;
        int              extra_at;
        int              cyc;
        take_bits(5, r);
        flen = frame_pkg::len_t'(r % 32'd24 + 32'd1);
        take_bits(16, r);
        seed = (r[15:0] == 16'h0) ? 16'h0001 : r[15:0];
        take_bits(16, r);
        poly = r[15:0];
        take_bits(2, r);
        do_extra = (r[1:0] == 2'd0);
        take_bits(5, r);
        extra_at = int'(r % ({24'd0, flen} + 32'd1));
        len = flen;
        start = 1'b1;
        expected_words += int'(flen) + 1;
        @(posedge clk);
        #1;
        start = 1'b0;
        len = ~len;  // inputs only count in the start cycle
        seed = ~seed;
        poly = ~poly;
        cyc = 0;
        while (busy === 1'b1) begin
            if (do_extra && (cyc == extra_at)) begin
                take_bits(5, r);
                len = frame_pkg::len_t'(r[4:0]);
                start = 1'b1;
            end
            @(posedge clk);
            #1;
            start = 1'b0;
            cyc++;
        end
    endtask

    task automatic idle_gap;
        logic [31:0] r;
        int          gap;
        logic        zero_start;
        take_bits(2, r);
        gap = int'(r[1:0]);
        take_bits(2, r);
        zero_start = (r[1:0] == 2'd0);
        for (int i = 0; i < gap; i++) begin
            start = (i == 0) && zero_start;  // an empty frame must be dropped
            len = '0;
            @(posedge clk);
            #1;
            start = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the frames did not finish within %0d ns", TIMEOUT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rstn = 1'b0;
        start = 1'b0;
        len = '0;
        seed = '0;
        poly = '0;
        rng_state = 32'h29b5;
        expected_words = 0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        repeat (3) @(posedge clk);  // outputs must stay quiet before the first start
        #1;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame();
            idle_gap();
        end
        repeat (4) @(posedge clk);
        #1;
        total_errors = error_count;
        if (frame_count != NUM_FRAMES) begin
            $display("wrong number of frames: %0d seen, %0d started", frame_count, NUM_FRAMES);
            total_errors++;
        end
        if (word_count != expected_words) begin
            $display("wrong number of words: %0d seen, %0d due", word_count, expected_words);
            total_errors++;
        end
        $display("frames %0d, words %0d, errors %0d", frame_count, word_count, total_errors);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
common/frame_pkg.sv
hw/lfsr_gen.sv
hw/word_counter.sv
hw/frame_fsm.sv
hw/crc_append.sv
hw/frame_gen_top.sv
testbench/frame_checker.sv
testbench/tb_frame_gen.sv

//--- run_sim.sh
#!/bin/sh
# compile the frame generator testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module tb_frame_gen -o tb_frame_gen

./obj_dir/tb_frame_gen 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
